//--- stream_pkg.sv
//////////////////////////////////////////////////
// shared widths, queue depth, register map and
// opcode encoding for the stream accelerator
//////////////////////////////////////////////////

`default_nettype none

package stream_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // message width on every stream
  localparam int DATA_W = 32;

  // apb address width
  localparam int ADDR_W = 12;

  //////////////////////////////////////////////////
  // queues
  //////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 2;

  // pointer and occupancy widths derived from the depth
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  // operand a queue
  localparam logic [ADDR_W-1:0] ADDR_A_STATUS = 12'h000;
  localparam logic [ADDR_W-1:0] ADDR_A_DATA   = 12'h004;

  // operand b queue
  localparam logic [ADDR_W-1:0] ADDR_B_STATUS = 12'h008;
  localparam logic [ADDR_W-1:0] ADDR_B_DATA   = 12'h00C;

  // result queue
  localparam logic [ADDR_W-1:0] ADDR_R_STATUS = 12'h010;
  localparam logic [ADDR_W-1:0] ADDR_R_DATA   = 12'h014;

  // opcode applied to the next pair taken by the join stage
  localparam logic [ADDR_W-1:0] ADDR_OPCODE   = 12'h018;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_SUB    = 2'd1,
    OP_XOR    = 2'd2,
    OP_MUL_LO = 2'd3
  } alu_op_e;

endpackage

`default_nettype wire

//--- stream_fifo.sv
//////////////////////////////////////////////////
// valid/ready queue as a circular buffer with count
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  input  wire logic                        enq_val_i,
  input  wire logic [stream_pkg::DATA_W-1:0] enq_data_i,
  output logic                             enq_rdy_o,
  output logic                             deq_val_o,
  input  wire logic                        deq_rdy_i,
  output logic [stream_pkg::DATA_W-1:0]    deq_data_o
);
  import stream_pkg::*;

  logic [DATA_W-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  full;
  logic                  enq_fire;
  logic                  deq_fire;

  assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign deq_val_o = (count != '0);
  assign deq_data_o = mem[rd_ptr];

  // a full queue still accepts when the head leaves this cycle
  assign enq_rdy_o = !full || deq_rdy_i;

  assign enq_fire = enq_val_i && enq_rdy_o;
  assign deq_fire = deq_val_o && deq_rdy_i;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // occupancy never runs past the depth
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n_i)
    count <= FIFO_CNT_W'(FIFO_DEPTH));

  // pointers only meet when the queue is empty or full
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_ptr == rd_ptr) |-> (count == '0 || full));

endmodule

`default_nettype wire

//--- apb_stream_bridge.sv
//////////////////////////////////////////////////
// apb slave with operand, result and opcode
// registers in front of the stream queues
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_stream_bridge (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  // apb
  input  wire logic [stream_pkg::ADDR_W-1:0] paddr_i,
  input  wire logic                          psel_i,
  input  wire logic                          penable_i,
  input  wire logic                          pwrite_i,
  input  wire logic [stream_pkg::DATA_W-1:0] pwdata_i,
  output logic [stream_pkg::DATA_W-1:0]      prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  // operand streams
  output logic                               a_val_o,
  input  wire logic                          a_rdy_i,
  output logic [stream_pkg::DATA_W-1:0]      a_data_o,
  output logic                               b_val_o,
  input  wire logic                          b_rdy_i,
  output logic [stream_pkg::DATA_W-1:0]      b_data_o,
  output stream_pkg::alu_op_e                op_o,
  // result stream
  input  wire logic                          res_val_i,
  output logic                               res_rdy_o,
  input  wire logic [stream_pkg::DATA_W-1:0] res_data_i
);
  import stream_pkg::*;

  logic              access;
  logic              wr_a;
  logic              wr_b;
  logic              wr_op;
  logic              pop_r;
  logic              a_enq_rdy;
  logic              b_enq_rdy;
  logic              r_deq_val;
  logic [DATA_W-1:0] r_deq_data;
  alu_op_e           op_q;

  // access phase of an apb transfer, pready is tied high
  assign access   = psel_i && penable_i;
  assign pready_o = 1'b1;

  //////////////////////////////////////////////////
  // decode and read mux
  //////////////////////////////////////////////////

  always_comb begin
    wr_a      = 1'b0;
    wr_b      = 1'b0;
    wr_op     = 1'b0;
    pop_r     = 1'b0;
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (access) begin
      case (paddr_i)
        ADDR_A_STATUS: begin
          if (pwrite_i) begin
            pslverr_o = 1'b1;
          end else begin
            prdata_o = {{(DATA_W-1){1'b0}}, a_enq_rdy};
          end
        end
        ADDR_A_DATA: begin
          if (pwrite_i) begin
            wr_a      = 1'b1;
            // word is dropped when the queue is full
            pslverr_o = !a_enq_rdy;
          end else begin
            pslverr_o = 1'b1;
          end
        end
        ADDR_B_STATUS: begin
          if (pwrite_i) begin
            pslverr_o = 1'b1;
          end else begin
            prdata_o = {{(DATA_W-1){1'b0}}, b_enq_rdy};
          end
        end
        ADDR_B_DATA: begin
          if (pwrite_i) begin
            wr_b      = 1'b1;
            pslverr_o = !b_enq_rdy;
          end else begin
            pslverr_o = 1'b1;
          end
        end
        ADDR_R_STATUS: begin
          if (pwrite_i) begin
            pslverr_o = 1'b1;
          end else begin
            prdata_o = {{(DATA_W-1){1'b0}}, r_deq_val};
          end
        end
        ADDR_R_DATA: begin
          if (pwrite_i) begin
            pslverr_o = 1'b1;
          end else begin
            pop_r = 1'b1;
            // empty pop reads zero
            if (r_deq_val) begin
              prdata_o = r_deq_data;
            end else begin
              pslverr_o = 1'b1;
            end
          end
        end
        ADDR_OPCODE: begin
          if (pwrite_i) begin
            wr_op = 1'b1;
          end else begin
            prdata_o = {{(DATA_W-2){1'b0}}, op_q};
          end
        end
        default: begin
          pslverr_o = 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // opcode register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      op_q <= OP_ADD;
    end else if (wr_op) begin
      op_q <= alu_op_e'(pwdata_i[1:0]);
    end
  end

  assign op_o = op_q;

  //////////////////////////////////////////////////
  // queues
  //////////////////////////////////////////////////

  stream_fifo u_q_a (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .enq_val_i  (wr_a),
    .enq_data_i (pwdata_i),
    .enq_rdy_o  (a_enq_rdy),
    .deq_val_o  (a_val_o),
    .deq_rdy_i  (a_rdy_i),
    .deq_data_o (a_data_o)
  );

  stream_fifo u_q_b (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .enq_val_i  (wr_b),
    .enq_data_i (pwdata_i),
    .enq_rdy_o  (b_enq_rdy),
    .deq_val_o  (b_val_o),
    .deq_rdy_i  (b_rdy_i),
    .deq_data_o (b_data_o)
  );

  stream_fifo u_q_r (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .enq_val_i  (res_val_i),
    .enq_data_i (res_data_i),
    .enq_rdy_o  (res_rdy_o),
    .deq_val_o  (r_deq_val),
    .deq_rdy_i  (pop_r),
    .deq_data_o (r_deq_data)
  );

  // an error only comes back in an access phase that follows its setup
  a_err_in_access : assert property (@(posedge clk) disable iff (!rst_n_i)
    pslverr_o |-> (access && $past(psel_i && !penable_i)));

endmodule

`default_nettype wire

//--- operand_join.sv
//////////////////////////////////////////////////
// join stage that pairs operand a with operand b
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operand_join (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic                          a_val_i,
  output logic                               a_rdy_o,
  input  wire logic [stream_pkg::DATA_W-1:0] a_data_i,
  input  wire logic                          b_val_i,
  output logic                               b_rdy_o,
  input  wire logic [stream_pkg::DATA_W-1:0] b_data_i,
  input  wire stream_pkg::alu_op_e           op_i,
  output logic                               pair_val_o,
  input  wire logic                          pair_rdy_i,
  output logic [stream_pkg::DATA_W-1:0]      pair_a_o,
  output logic [stream_pkg::DATA_W-1:0]      pair_b_o,
  output stream_pkg::alu_op_e                pair_op_o
);
  import stream_pkg::*;

  logic take;

  // both operands leave together once the register is empty or draining
  assign take    = a_val_i && b_val_i && (!pair_val_o || pair_rdy_i);
  assign a_rdy_o = take;
  assign b_rdy_o = take;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pair_val_o <= 1'b0;
    end else if (take) begin
      pair_val_o <= 1'b1;
    end else if (pair_rdy_i) begin
      pair_val_o <= 1'b0;
    end
  end

  // opcode is sampled with the pair
  always_ff @(posedge clk) begin
    if (take) begin
      pair_a_o  <= a_data_i;
      pair_b_o  <= b_data_i;
      pair_op_o <= op_i;
    end
  end

  // an offered operand stays put until it is taken
  a_a_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    (a_val_i && !a_rdy_o) |=> (a_val_i && $stable(a_data_i)));

  a_b_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    (b_val_i && !b_rdy_o) |=> (b_val_i && $stable(b_data_i)));

endmodule

`default_nettype wire

//--- alu_stage.sv
//////////////////////////////////////////////////
// execute stage with opcode datapath and result reg
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu_stage (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic                          pair_val_i,
  output logic                               pair_rdy_o,
  input  wire logic [stream_pkg::DATA_W-1:0] pair_a_i,
  input  wire logic [stream_pkg::DATA_W-1:0] pair_b_i,
  input  wire stream_pkg::alu_op_e           pair_op_i,
  output logic                               res_val_o,
  input  wire logic                          res_rdy_i,
  output logic [stream_pkg::DATA_W-1:0]      res_data_o
);
  import stream_pkg::*;

  logic [DATA_W-1:0] result;
  logic              load;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  always_comb begin
    case (pair_op_i)
      OP_ADD:    result = pair_a_i + pair_b_i;
      OP_SUB:    result = pair_a_i - pair_b_i;
      OP_XOR:    result = pair_a_i ^ pair_b_i;
      // only the low word of the product is kept
      OP_MUL_LO: result = DATA_W'(pair_a_i * pair_b_i);
      default:   result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////

  assign pair_rdy_o = !res_val_o || res_rdy_i;
  assign load       = pair_val_i && pair_rdy_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      res_val_o <= 1'b0;
    end else if (load) begin
      res_val_o <= 1'b1;
    end else if (res_rdy_i) begin
      res_val_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      res_data_o <= result;
    end
  end

  // a stalled pair stays on the input until it is loaded
  a_pair_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    (pair_val_i && !pair_rdy_o) |=> (pair_val_i && $stable(pair_a_i) && $stable(pair_b_i)
      && $stable(pair_op_i)));

endmodule

`default_nettype wire

//--- stream_accel_top.sv
//////////////////////////////////////////////////
// top level, apb bridge and the two pipeline stages
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stream_accel_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic [stream_pkg::ADDR_W-1:0] paddr_i,
  input  wire logic                          psel_i,
  input  wire logic                          penable_i,
  input  wire logic                          pwrite_i,
  input  wire logic [stream_pkg::DATA_W-1:0] pwdata_i,
  output logic [stream_pkg::DATA_W-1:0]      prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o
);
  import stream_pkg::*;

  // operand streams
  logic              a_val;
  logic              a_rdy;
  logic [DATA_W-1:0] a_data;
  logic              b_val;
  logic              b_rdy;
  logic [DATA_W-1:0] b_data;
  alu_op_e           op;

  // join to execute
  logic              pair_val;
  logic              pair_rdy;
  logic [DATA_W-1:0] pair_a;
  logic [DATA_W-1:0] pair_b;
  alu_op_e           pair_op;

  // execute to result queue
  logic              res_val;
  logic              res_rdy;
  logic [DATA_W-1:0] res_data;

  apb_stream_bridge u_bridge (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .a_val_o    (a_val),
    .a_rdy_i    (a_rdy),
    .a_data_o   (a_data),
    .b_val_o    (b_val),
    .b_rdy_i    (b_rdy),
    .b_data_o   (b_data),
    .op_o       (op),
    .res_val_i  (res_val),
    .res_rdy_o  (res_rdy),
    .res_data_i (res_data)
  );

  operand_join u_join (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .a_val_i    (a_val),
    .a_rdy_o    (a_rdy),
    .a_data_i   (a_data),
    .b_val_i    (b_val),
    .b_rdy_o    (b_rdy),
    .b_data_i   (b_data),
    .op_i       (op),
    .pair_val_o (pair_val),
    .pair_rdy_i (pair_rdy),
    .pair_a_o   (pair_a),
    .pair_b_o   (pair_b),
    .pair_op_o  (pair_op)
  );

  alu_stage u_alu (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .pair_val_i (pair_val),
    .pair_rdy_o (pair_rdy),
    .pair_a_i   (pair_a),
    .pair_b_i   (pair_b),
    .pair_op_i  (pair_op),
    .res_val_o  (res_val),
    .res_rdy_i  (res_rdy),
    .res_data_o (res_data)
  );

endmodule

`default_nettype wire

//--- tb_stream_accel.sv
//////////////////////////////////////////////////
// testbench for the stream accelerator with apb tasks,
// lfsr operands, result model, checks and timeout
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_stream_accel;
  import stream_pkg::*;

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 8;
  localparam logic [15:0] LFSR_SEED    = 16'd49555;
  // status polls allowed while waiting for one result
  localparam int          POLL_LIMIT   = 40;
  // upper bound on tests times the cycle budget of one test
  localparam int          MAX_TESTS    = 100;
  localparam int          TEST_BUDGET  = 200;
  localparam int          CYCLE_LIMIT  = MAX_TESTS * TEST_BUDGET;
  localparam int          RAND_PAIRS   = 8;
  localparam int          BATCH        = 4;
  // 2 per input queue, 1 per stage, 2 in the result queue
  localparam int          PIPE_DEPTH   = 6;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  logic [15:0]       lfsr_state;
  logic [DATA_W-1:0] expected_q[$];
  int                cycle_count;

  stream_accel_top dut0 (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // reporting and reference model
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  function automatic logic [DATA_W-1:0] random_word();
    logic [DATA_W-1:0] word;
    word = '0;
    for (int i = 0; i < DATA_W; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word       = {word[DATA_W-2:0], lfsr_state[0]};
    end
    return word;
  endfunction

  function automatic logic [DATA_W-1:0] model_result(input logic [1:0] op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] product;
    product = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      // two's complement negation of b
      OP_SUB:  return a + ~b + 1;
      OP_XOR:  return (a | b) & ~(a & b);
      default: return product[DATA_W-1:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // apb access
  //////////////////////////////////////////////////

  task automatic bus_transfer(input logic is_write, input logic [ADDR_W-1:0] addr,
      input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = is_write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // sample mid access phase
    #(CLK_PERIOD/4);
    // no wait states, every access phase is a single cycle
    check_value($sformatf("pready at %h", addr), 32'd1, pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    logic [DATA_W-1:0] unused;
    bus_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  //////////////////////////////////////////////////
  // test steps
  //////////////////////////////////////////////////

  task automatic check_status(input string name, input logic [ADDR_W-1:0] addr,
                              input logic expected);
    logic [DATA_W-1:0] data;
    logic              err;
    apb_read(addr, data, err);
    check_value({name, " pslverr"}, '0, err);
    check_value(name, {{(DATA_W-1){1'b0}}, expected}, data);
  endtask

  task automatic expect_error(input string name, input logic is_write,
                              input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] data;
    logic              err;
    bus_transfer(is_write, addr, 32'hFFFF_FFFF, data, err);
    check_value({name, " pslverr"}, 1, err);
  endtask

  task automatic set_opcode(input string name, input logic [1:0] op);
    logic [DATA_W-1:0] data;
    logic              err;
    apb_write(ADDR_OPCODE, {{(DATA_W-2){1'b0}}, op}, err);
    check_value({name, " opcode write pslverr"}, '0, err);
    apb_read(ADDR_OPCODE, data, err);
    check_value({name, " opcode readback"}, {{(DATA_W-2){1'b0}}, op}, data);
  endtask

  task automatic write_pair(input string name, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
    logic err;
    apb_write(ADDR_A_DATA, a, err);
    check_value({name, " a write pslverr"}, '0, err);
    apb_write(ADDR_B_DATA, b, err);
    check_value({name, " b write pslverr"}, '0, err);
  endtask

  task automatic read_result(input string name, input logic [DATA_W-1:0] expected);
    logic [DATA_W-1:0] data;
    logic              err;
    int                polls;
    polls = 0;
    apb_read(ADDR_R_STATUS, data, err);
    while (data[0] !== 1'b1) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        $display("%s: no result arrived after %0d status polls", name, POLL_LIMIT);
        abort_run();
      end
      apb_read(ADDR_R_STATUS, data, err);
    end
    apb_read(ADDR_R_DATA, data, err);
    check_value({name, " pop pslverr"}, '0, err);
    check_value(name, expected, data);
  endtask

  task automatic drain_results(input string name);
    logic [DATA_W-1:0] expected;
    int                idx;
    idx = 0;
    while (expected_q.size() > 0) begin
      expected = expected_q.pop_front();
      read_result($sformatf("%s result %0d", name, idx), expected);
      idx++;
    end
  endtask

  task automatic run_directed();
    int                fd;
    int                n;
    int                vec_op;
    logic [DATA_W-1:0] vec_a;
    logic [DATA_W-1:0] vec_b;
    logic [DATA_W-1:0] vec_exp;
    string             name;
    fd = $fopen("tb_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tb_input.txt");
      abort_run();
    end
    n = 0;
    while ($fscanf(fd, "%d %h %h %h", vec_op, vec_a, vec_b, vec_exp) == 4) begin
      name = $sformatf("vector %0d", n);
      check_value({name, " model"}, vec_exp, model_result(2'(vec_op), vec_a, vec_b));
      set_opcode(name, 2'(vec_op));
      write_pair(name, vec_a, vec_b);
      read_result(name, vec_exp);
      n++;
    end
    $fclose(fd);
    if (n == 0) begin
      $display("tb_input.txt holds no vectors");
      abort_run();
    end
  endtask

  task automatic run_random();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    string             name;
    for (int k = 0; k < 4; k++) begin
      set_opcode($sformatf("random op %0d", k), 2'(k));
      for (int i = 0; i < RAND_PAIRS; i++) begin
        a    = random_word();
        b    = random_word();
        name = $sformatf("random op %0d pair %0d", k, i);
        write_pair(name, a, b);
        expected_q.push_back(model_result(2'(k), a, b));
        // drain before the queue depth is reached and before an opcode change
        if (i % BATCH == BATCH - 1) begin
          drain_results(name);
        end
      end
    end
  endtask

  task automatic run_backpressure();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              err;
    set_opcode("backpressure", OP_SUB);
    for (int i = 0; i < PIPE_DEPTH; i++) begin
      a = random_word();
      b = random_word();
      write_pair($sformatf("backpressure pair %0d", i), a, b);
      expected_q.push_back(model_result(OP_SUB, a, b));
    end
    repeat (12) @(negedge clk);
    check_status("backpressure a status", ADDR_A_STATUS, 1'b0);
    check_status("backpressure b status", ADDR_B_STATUS, 1'b0);
    check_status("backpressure r status", ADDR_R_STATUS, 1'b1);
    apb_write(ADDR_A_DATA, random_word(), err);
    check_value("backpressure extra a write pslverr", 1, err);
    drain_results("backpressure");
    // the dropped word must not pair with this one
    write_pair("after backpressure", 32'd100, 32'd58);
    read_result("after backpressure", model_result(OP_SUB, 32'd100, 32'd58));
    check_status("after backpressure r status", ADDR_R_STATUS, 1'b0);
  endtask

  task automatic run_error_cases();
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              err;
    apb_read(ADDR_R_DATA, data, err);
    check_value("empty pop pslverr", 1, err);
    check_value("empty pop data", '0, data);
    expect_error("a status write", 1'b1, ADDR_A_STATUS);
    expect_error("b status write", 1'b1, ADDR_B_STATUS);
    expect_error("r status write", 1'b1, ADDR_R_STATUS);
    expect_error("a data read", 1'b0, ADDR_A_DATA);
    expect_error("b data read", 1'b0, ADDR_B_DATA);
    expect_error("unmapped write", 1'b1, 12'h01C);
    expect_error("unmapped read", 1'b0, 12'h01C);
    expect_error("misaligned write", 1'b1, 12'h006);
    // only the low two opcode bits are kept
    apb_write(ADDR_OPCODE, 32'hFFFF_FFFD, err);
    check_value("wide opcode write pslverr", '0, err);
    apb_read(ADDR_OPCODE, data, err);
    check_value("wide opcode readback", 32'd1, data);
    check_status("errors a status", ADDR_A_STATUS, 1'b1);
    check_status("errors b status", ADDR_B_STATUS, 1'b1);
    check_status("errors r status", ADDR_R_STATUS, 1'b0);
    set_opcode("after errors", OP_XOR);
    a = random_word();
    b = random_word();
    write_pair("after errors", a, b);
    read_result("after errors", model_result(OP_XOR, a, b));
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    cycle_count = 0;
    lfsr_state  = LFSR_SEED;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    check_status("reset a status", ADDR_A_STATUS, 1'b1);
    check_status("reset b status", ADDR_B_STATUS, 1'b1);
    check_status("reset r status", ADDR_R_STATUS, 1'b0);
    check_status("reset opcode", ADDR_OPCODE, 1'b0);

    run_directed();
    run_random();
    run_backpressure();
    run_error_cases();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_input.txt
0 00000001 00000002 00000003
0 ffffffff 00000001 00000000
0 7fffffff 7fffffff fffffffe
0 deadbeef 21524111 00000000
1 00000005 00000003 00000002
1 00000000 00000001 ffffffff
1 80000000 00000001 7fffffff
1 00000010 00000020 fffffff0
2 a5a5a5a5 5a5a5a5a ffffffff
2 12345678 12345678 00000000
2 00000000 ffffffff ffffffff
3 00000003 00000007 00000015
3 ffffffff ffffffff 00000001
3 00010000 00010000 00000000
3 12345678 00000010 23456780

//--- sim.f
stream_pkg.sv
stream_fifo.sv
apb_stream_bridge.sv
operand_join.sv
alu_stage.sv
stream_accel_top.sv
tb_stream_accel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the stream accelerator testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_stream_accel -o sim_tb

# no pipefail, so a failing run still reaches the log search
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
